// File: include/floor_consts.svh
////////////////////////////////////////////////////////////
// Project-wide floor constants for the request logic
// Include before floor_pkg types or floor loops are used
////////////////////////////////////////////////////////////

`ifndef FLOOR_CONSTS_SVH
`define FLOOR_CONSTS_SVH

// Number of floors served by the car
`define FLOOR_COUNT 11

// Bits needed for one floor index
`define FLOOR_WIDTH 4

// Highest floor index, ground floor is zero
`define TOP_FLOOR 10

`endif

// File: hdl/floor_pkg.sv
////////////////////////////////////////////////////////////
// Shared types for the floor request logic
// Imported by every module of the design
////////////////////////////////////////////////////////////

`include "floor_consts.svh"

package floor_pkg;

    // Floor index, zero is the first floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, used for buttons and lights
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // Dispatch control states
    typedef enum logic [1:0] {
        IDLE,
        TRAVEL,
        ARRIVE,
        HALT
    } dispatch_state_t;

endpackage

// File: hdl/request_latch.sv
////////////////////////////////////////////////////////////
// Hall call and cab panel request lights
// Presses set lights, arrival clears the current floor
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module request_latch import floor_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  floor_t      current_floor,
    input  logic        emergency_button,
    input  logic        power_switch,
    input  logic        arrive_clear,
    output floor_mask_t call_lights,
    output floor_mask_t panel_lights
);

    logic        run;
    floor_mask_t here_mask;
    floor_mask_t clear_mask;
    floor_mask_t call_next;
    floor_mask_t panel_next;

    // Latching is live only with power on and no emergency
    assign run = power_switch && !emergency_button;

    // One-hot mask of the floor the car is at
    assign here_mask = floor_mask_t'(1) << current_floor;

    assign clear_mask = arrive_clear ? here_mask : '0;

    // A press at the current floor never lights, so clearing wins
    assign call_next  = (call_lights & ~clear_mask) | (floor_call_buttons & ~here_mask);
    assign panel_next = (panel_lights & ~clear_mask) | (panel_buttons & ~here_mask);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else if (run) begin
            call_lights  <= call_next;
            panel_lights <= panel_next;
        end
    end

endmodule

// File: hdl/target_selector.sv
////////////////////////////////////////////////////////////
// Directional search for the next target floor
// Nearest pending floor ahead in the sweep, else behind
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "floor_consts.svh"

module target_selector import floor_pkg::*; (
    input  floor_mask_t call_lights,
    input  floor_mask_t panel_lights,
    input  floor_t      current_floor,
    input  logic        sweep_up,
    output floor_t      target_floor,
    output logic        target_valid,
    output logic        target_up
);

    floor_mask_t pending;
    floor_t      above_floor;
    floor_t      below_floor;
    logic        has_above;
    logic        has_below;

    // Requests from both panels, minus the floor we are at
    assign pending = (call_lights | panel_lights) & ~(floor_mask_t'(1) << current_floor);

    // Nearest pending floor strictly above
    // Scan from the top down so the last hit is the closest one
    always_comb begin
        above_floor = current_floor;
        has_above   = 1'b0;
        for (int i = `TOP_FLOOR; i >= 0; i--) begin
            if (pending[i] && floor_t'(i) > current_floor) begin
                above_floor = floor_t'(i);
                has_above   = 1'b1;
            end
        end
    end

    // Nearest pending floor strictly below, scanned upward
    always_comb begin
        below_floor = current_floor;
        has_below   = 1'b0;
        for (int i = 0; i <= `TOP_FLOOR; i++) begin
            if (pending[i] && floor_t'(i) < current_floor) begin
                below_floor = floor_t'(i);
                has_below   = 1'b1;
            end
        end
    end

    // Keep the sweep going, turn around only when nothing is ahead
    always_comb begin
        if (sweep_up) begin
            target_floor = has_above ? above_floor : below_floor;
        end else begin
            target_floor = has_below ? below_floor : above_floor;
        end
    end

    assign target_valid = has_above || has_below;
    assign target_up    = target_floor > current_floor;

endmodule

// File: hdl/dispatch_control.sv
////////////////////////////////////////////////////////////
// Dispatch FSM: commits a target, waits for the car,
// signals arrival, and gates the door buttons
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dispatch_control import floor_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  floor_t target_floor,
    input  logic   target_valid,
    input  logic   target_up,
    input  floor_t current_floor,
    input  logic   car_moving,
    input  logic   emergency_button,
    input  logic   power_switch,
    input  logic   door_open_button,
    input  logic   door_close_button,
    output floor_t floor_selector,
    output logic   direction_up,
    output logic   activate_elevator,
    output logic   arrive_clear,
    output logic   sweep_up,
    output logic   door_open_allowed,
    output logic   door_close_allowed
);

    dispatch_state_t state;
    logic            halt_request;
    logic            at_target;
    logic            door_gate;

    assign halt_request = emergency_button || !power_switch;

    // Car has stopped at the committed floor
    assign at_target = (current_floor == floor_selector) && !car_moving;

    // Doors may only be worked on a stopped, powered car between trips
    assign door_gate = !car_moving && power_switch && (state == IDLE || state == ARRIVE);

    // Command and arrival strobe decode straight from the state
    assign activate_elevator = (state == TRAVEL);
    assign arrive_clear      = (state == ARRIVE);

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= IDLE;
            floor_selector <= '0;
            direction_up   <= 1'b0;
            sweep_up       <= 1'b1;
        end else if (halt_request) begin
            // Withdraw any command until both conditions clear
            state <= HALT;
        end else begin
            case (state)
                IDLE: begin
                    if (target_valid && !car_moving) begin
                        floor_selector <= target_floor;
                        direction_up   <= target_up;
                        sweep_up       <= target_up;
                        state          <= TRAVEL;
                    end
                end
                TRAVEL: begin
                    // Target is frozen here, new lights wait for the next pass
                    if (at_target) begin
                        state <= ARRIVE;
                    end
                end
                ARRIVE: begin
                    state <= IDLE;
                end
                HALT: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Door permits, one cycle behind the buttons
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_gate && door_open_button;
            door_close_allowed <= door_gate && door_close_button;
        end
    end

endmodule

// File: hdl/floor_request_top.sv
////////////////////////////////////////////////////////////
// Floor request logic top level
// Buttons and car status in, dispatch command and lights out
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floor_request_top import floor_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t floor_call_buttons,
    input  floor_mask_t panel_buttons,
    input  logic        door_open_button,
    input  logic        door_close_button,
    input  logic        emergency_button,
    input  logic        power_switch,
    input  floor_t      current_floor,
    input  logic        car_moving,
    output floor_t      floor_selector,
    output logic        direction_up,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed,
    output floor_mask_t call_lights,
    output floor_mask_t panel_lights
);

    // Selector to control
    floor_t target_floor;
    logic   target_valid;
    logic   target_up;

    // Control back to latch and selector
    logic   arrive_clear;
    logic   sweep_up;

    request_latch u_request_latch (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .current_floor      (current_floor),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .arrive_clear       (arrive_clear),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights)
    );

    target_selector u_target_selector (
        .call_lights   (call_lights),
        .panel_lights  (panel_lights),
        .current_floor (current_floor),
        .sweep_up      (sweep_up),
        .target_floor  (target_floor),
        .target_valid  (target_valid),
        .target_up     (target_up)
    );

    dispatch_control u_dispatch_control (
        .clock              (clock),
        .reset_n            (reset_n),
        .target_floor       (target_floor),
        .target_valid       (target_valid),
        .target_up          (target_up),
        .current_floor      (current_floor),
        .car_moving         (car_moving),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .floor_selector     (floor_selector),
        .direction_up       (direction_up),
        .activate_elevator  (activate_elevator),
        .arrive_clear       (arrive_clear),
        .sweep_up           (sweep_up),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: bench/car_model.sv
////////////////////////////////////////////////////////////
// Behavioral elevator car for the testbench
// Steps one floor every six cycles while commanded
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module car_model import floor_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   activate_elevator,
    input  floor_t floor_selector,
    output floor_t current_floor,
    output logic   car_moving
);

    localparam logic [2:0] STEP_CYCLES = 3'd6;

    logic [2:0] step_count;

    // Car parks at floor zero and moves only under command
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            current_floor <= '0;
            car_moving    <= 1'b0;
            step_count    <= '0;
        end else if (activate_elevator && current_floor != floor_selector) begin
            car_moving <= 1'b1;
            if (step_count == STEP_CYCLES - 3'd1) begin
                step_count <= '0;
                if (floor_selector > current_floor) begin
                    current_floor <= current_floor + floor_t'(1);
                end else begin
                    current_floor <= current_floor - floor_t'(1);
                end
            end else begin
                step_count <= step_count + 3'd1;
            end
        end else begin
            // At the target or command withdrawn
            car_moving <= 1'b0;
            step_count <= '0;
        end
    end

endmodule

// File: bench/tb_floor_request_top.sv
////////////////////////////////////////////////////////////
// Testbench for the floor request logic with a behavioral car
// Random presses and halts, compared against a cycle model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "floor_consts.svh"

module tb_floor_request_top import floor_pkg::*; ();

    localparam int STIM_CYCLES    = 2000;
    localparam int HALT_START     = 1400;
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    floor_t      current_floor;
    logic        car_moving;
    floor_t      floor_selector;
    logic        direction_up;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;

    // Reference model state
    dispatch_state_t       model_state;
    floor_mask_t           model_call;
    floor_mask_t           model_panel;
    floor_t                model_selector;
    logic                  model_dir;
    logic                  model_sweep;
    logic                  model_open;
    logic                  model_close;
    logic                  halt_seen;
    floor_mask_t           next_call;
    floor_mask_t           next_panel;
    floor_mask_t           bit_mask;
    logic [`FLOOR_WIDTH:0] model_pick;

    logic [31:0] rng;
    int          halt_left;
    logic        halt_is_power;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          dispatches = 0;
    logic        active_prev = 1'b0;

    floor_request_top u_floor_request_top (.*);

    car_model u_car_model (
        .clock             (clock),
        .reset_n           (reset_n),
        .activate_elevator (activate_elevator),
        .floor_selector    (floor_selector),
        .current_floor     (current_floor),
        .car_moving        (car_moving)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Returns {valid, floor}
    function automatic logic [`FLOOR_WIDTH:0] pick_target(input floor_mask_t lights,
                                                          input floor_t cur, input logic sweep);
        int                    c;
        int                    f;
        logic [`FLOOR_WIDTH:0] pick;
        pick = '0;
        c = int'(cur);
        // Scan far to near so the nearest hit stays
        for (int d = `TOP_FLOOR; d >= 1; d--) begin
            f = sweep ? c - d : c + d;
            if (f >= 0 && f <= `TOP_FLOOR && (lights & (floor_mask_t'(1) << f)) != '0) begin
                pick = {1'b1, floor_t'(f)};
            end
        end
        // Floors ahead of the sweep override anything behind
        for (int d = `TOP_FLOOR; d >= 1; d--) begin
            f = sweep ? c + d : c - d;
            if (f >= 0 && f <= `TOP_FLOOR && (lights & (floor_mask_t'(1) << f)) != '0) begin
                pick = {1'b1, floor_t'(f)};
            end
        end
        return pick;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    assign model_pick = pick_target(model_call | model_panel, current_floor, model_sweep);

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            model_state    <= IDLE;
            model_call     <= '0;
            model_panel    <= '0;
            model_selector <= '0;
            model_dir      <= 1'b0;
            model_sweep    <= 1'b1;
            model_open     <= 1'b0;
            model_close    <= 1'b0;
            halt_seen      <= 1'b0;
        end else begin
            next_call  = model_call;
            next_panel = model_panel;
            for (int i = 0; i < `FLOOR_COUNT; i++) begin
                bit_mask = floor_mask_t'(1) << i;
                if (i == int'(current_floor)) begin
                    // Arrival wipes both lights here and presses here are ignored
                    if (model_state == ARRIVE) begin
                        next_call  = next_call & ~bit_mask;
                        next_panel = next_panel & ~bit_mask;
                    end
                end else begin
                    if ((floor_call_buttons & bit_mask) != '0) begin
                        next_call = next_call | bit_mask;
                    end
                    if ((panel_buttons & bit_mask) != '0) begin
                        next_panel = next_panel | bit_mask;
                    end
                end
            end
            if (power_switch && !emergency_button) begin
                model_call  <= next_call;
                model_panel <= next_panel;
            end

            halt_seen <= emergency_button || !power_switch;
            if (emergency_button || !power_switch) begin
                model_state <= HALT;
            end else begin
                case (model_state)
                    IDLE: begin
                        if (model_pick[`FLOOR_WIDTH] && !car_moving) begin
                            model_selector <= model_pick[`FLOOR_WIDTH-1:0];
                            model_dir      <= model_pick[`FLOOR_WIDTH-1:0] > current_floor;
                            model_sweep    <= model_pick[`FLOOR_WIDTH-1:0] > current_floor;
                            model_state    <= TRAVEL;
                        end
                    end
                    TRAVEL: begin
                        if (current_floor == model_selector && !car_moving) begin
                            model_state <= ARRIVE;
                        end
                    end
                    default: begin
                        model_state <= IDLE;
                    end
                endcase
            end

            // Doors only on a stopped, powered car between trips
            model_open  <= door_open_button && !car_moving && power_switch &&
                           (model_state == IDLE || model_state == ARRIVE);
            model_close <= door_close_button && !car_moving && power_switch &&
                           (model_state == IDLE || model_state == ARRIVE);
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks on the falling edge of the clock
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        check_value("call_lights", 32'(model_call), 32'(call_lights));
        check_value("panel_lights", 32'(model_panel), 32'(panel_lights));
        check_value("activate", 32'(model_state == TRAVEL), 32'(activate_elevator));
        check_value("target_floor", 32'(model_selector), 32'(floor_selector));
        check_value("target_dir", 32'(model_dir), 32'(direction_up));
        check_value("door_open", 32'(model_open), 32'(door_open_allowed));
        check_value("door_close", 32'(model_close), 32'(door_close_allowed));
        if (halt_seen) begin
            check_value("halt", 32'd0, 32'(activate_elevator));
        end
        if (activate_elevator && !active_prev) begin
            dispatches++;
        end
        active_prev = activate_elevator;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run hung: still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks %0d, errors %0d, dispatches %0d", checks, errors, dispatches);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_button   = 1'b0;
        door_close_button  = 1'b0;
        emergency_button   = 1'b0;
        power_switch       = 1'b1;
        rng                = 32'd51;
        halt_left          = 0;
        halt_is_power      = 1'b0;

        repeat (4) @(posedge clock);
        reset_n <= 1'b1;

        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            @(posedge clock);
            rng = xorshift(rng);
            floor_call_buttons <= (rng[3:0] == 4'd0) ?
                                  floor_mask_t'(1) << (int'(rng[15:8]) % `FLOOR_COUNT) : '0;
            panel_buttons      <= (rng[7:4] == 4'd0) ?
                                  floor_mask_t'(1) << (int'(rng[23:16]) % `FLOOR_COUNT) : '0;
            door_open_button   <= rng[24];
            door_close_button  <= rng[25];
            // Rare short halts late in the run
            if (cyc >= HALT_START && halt_left == 0 && rng[31:26] == 6'd0) begin
                rng = xorshift(rng);
                halt_left     = 1 + int'(rng[2:0]);
                halt_is_power = rng[3];
            end
            emergency_button <= (halt_left > 0) && !halt_is_power;
            power_switch     <= !((halt_left > 0) && halt_is_power);
            if (halt_left > 0) begin
                halt_left--;
            end
        end

        // Quiet inputs and let the car serve what is left
        @(posedge clock);
        floor_call_buttons <= '0;
        panel_buttons      <= '0;
        door_open_button   <= 1'b0;
        door_close_button  <= 1'b0;
        emergency_button   <= 1'b0;
        power_switch       <= 1'b1;
        @(posedge clock);
        while (model_state != IDLE || model_pick[`FLOOR_WIDTH] || car_moving) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);

        assert (dispatches > 0) else begin
            errors++;
            $display("No dispatch happened during the run");
        end
        $display("Checks %0d, errors %0d, dispatches %0d", checks, errors, dispatches);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: floor_request_top.f
+incdir+include
hdl/floor_pkg.sv
hdl/request_latch.sv
hdl/target_selector.sv
hdl/dispatch_control.sv
hdl/floor_request_top.sv
bench/car_model.sv
bench/tb_floor_request_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_floor_request_top
FILELIST = floor_request_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Verdict comes from the log, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
